/* rtl/float_defines.svh */
// single-precision format only; the derived widths below assume the hidden one is restored
`ifndef FLOAT_DEFINES_SVH
`define FLOAT_DEFINES_SVH

// stored word layout
`define FLOAT_WIDTH           32
`define FLOAT_EXP_WIDTH       8
`define FLOAT_MANT_WIDTH      23
`define FLOAT_EXP_BIAS        127

// significand with the hidden one in front of the stored mantissa
`define FLOAT_SIG_WIDTH       (`FLOAT_MANT_WIDTH + 1)

// full significand product, two integer bits on top
`define FLOAT_PROD_WIDTH      (2 * `FLOAT_SIG_WIDTH)

// signed exponent after bias removal, wide enough for sum minus bias
`define FLOAT_PROD_EXP_WIDTH  (`FLOAT_EXP_WIDTH + 2)

`endif

/* rtl/float_pkg.sv */
// word format types for one float layout; field order is sign, exponent, stored mantissa
`include "float_defines.svh"

package float_pkg;

    // field view of a word, msb first as it sits in memory
    typedef struct packed {
        logic                            sign;
        logic [`FLOAT_EXP_WIDTH-1:0]     exp;
        logic [`FLOAT_MANT_WIDTH-1:0]    mant;
    } float_fields_t;

    // one word read two ways
    // raw is what travels on a port, fields is used to decode and to pack
    typedef union packed {
        logic [`FLOAT_WIDTH-1:0]         raw;
        float_fields_t                   fields;
    } float_t;

    // an exponent of all zeros marks zero or denormal here
    function automatic logic is_zero_exp(input float_t f);
        logic zero_exp;
        zero_exp = (f.fields.exp == '0);
        return zero_exp;
    endfunction

endpackage

/* rtl/fmul_pkg.sv */
// pipeline stage records of the multiplier; each record carries its own valid bit
`include "float_defines.svh"

package fmul_pkg;

    // significand with hidden one, and the full product of two of them
    typedef logic [`FLOAT_SIG_WIDTH-1:0]                sig_t;
    typedef logic [`FLOAT_PROD_WIDTH-1:0]               sig_prod_t;

    // exponent after bias removal, signed so a low sum shows as negative
    typedef logic signed [`FLOAT_PROD_EXP_WIDTH-1:0]    prod_exp_t;

    // decoded operands, output of the input stage
    typedef struct packed {
        logic                           valid;
        logic                           zero;
        logic                           a_sign;
        logic                           b_sign;
        logic [`FLOAT_EXP_WIDTH-1:0]    a_exp;
        logic [`FLOAT_EXP_WIDTH-1:0]    b_exp;
        sig_t                           a_sig;
        sig_t                           b_sig;
    } operand_pair_t;

    // raw product before normalization, output of the multiply stage
    typedef struct packed {
        logic                           valid;
        logic                           zero;
        logic                           sign;
        prod_exp_t                      exp;
        sig_prod_t                      sig;
    } product_t;

endpackage

/* rtl/float_unpack.sv */
// a and b are only looked at when req is high; a zero exponent on either side yields zero
`timescale 1ns/1ps

module float_unpack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  float_pkg::float_t        a,
    input  float_pkg::float_t        b,
    output fmul_pkg::operand_pair_t  opnd
);

    fmul_pkg::operand_pair_t  opnd_next;
    logic                     a_zero;
    logic                     b_zero;
    logic                     any_zero;

    // zero or denormal check per operand
    always_comb begin
        a_zero   = float_pkg::is_zero_exp(a);
        b_zero   = float_pkg::is_zero_exp(b);
        any_zero = a_zero | b_zero;
    end

    always_comb begin
        opnd_next = '0;

        opnd_next.valid  = req;
        opnd_next.zero   = any_zero;

        // signs and exponents come straight from the field view
        opnd_next.a_sign = a.fields.sign;
        opnd_next.b_sign = b.fields.sign;
        opnd_next.a_exp  = a.fields.exp;
        opnd_next.b_exp  = b.fields.exp;

        // restore hidden one, leave both significands at zero for the zero case
        // so the multiplier sees quiet inputs
        if (!any_zero) begin
            opnd_next.a_sig = {1'b1, a.fields.mant};
            opnd_next.b_sig = {1'b1, b.fields.mant};
        end
    end

    // stage register, loads every cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opnd <= '0;
        end else begin
            opnd <= opnd_next;
        end
    end

endmodule

/* rtl/float_mant_mul.sv */
// no rounding and no exponent range check; the exponent may go negative or past 255 here
`timescale 1ns/1ps
`include "float_defines.svh"

module float_mant_mul (
    input  logic                     clk,
    input  logic                     rst,
    input  fmul_pkg::operand_pair_t  opnd,
    output fmul_pkg::product_t       prod
);

    fmul_pkg::product_t   prod_next;
    fmul_pkg::prod_exp_t  exp_sum;
    fmul_pkg::sig_prod_t  sig_prod;

    // biased exponents add up to twice the bias, take one bias back out
    always_comb begin
        exp_sum = fmul_pkg::prod_exp_t'(opnd.a_exp)
                + fmul_pkg::prod_exp_t'(opnd.b_exp)
                - fmul_pkg::prod_exp_t'(`FLOAT_EXP_BIAS);
    end

    // 24 x 24 significand multiply, the long path of the unit
    always_comb begin
        sig_prod = fmul_pkg::sig_prod_t'(opnd.a_sig) * fmul_pkg::sig_prod_t'(opnd.b_sig);
    end

    always_comb begin
        prod_next.valid = opnd.valid;
        prod_next.zero  = opnd.zero;
        prod_next.sign  = opnd.a_sign ^ opnd.b_sign;
        prod_next.exp   = exp_sum;
        prod_next.sig   = sig_prod;
    end

    // stage register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prod <= '0;
        end else begin
            prod <= prod_next;
        end
    end

endmodule

/* rtl/float_normalize.sv */
// mantissa is truncated, exponent wraps to 8 bits; out is held at zero when ack is low
`timescale 1ns/1ps
`include "float_defines.svh"

module float_normalize (
    input  logic                 clk,
    input  logic                 rst,
    input  fmul_pkg::product_t   prod,
    output float_pkg::float_t    out,
    output logic                 ack
);

    float_pkg::float_t                   out_next;
    logic                                carry;
    fmul_pkg::prod_exp_t                 exp_adj;
    logic [`FLOAT_MANT_WIDTH-1:0]        mant_norm;

    // product of two values in [1,2) lies in [1,4)
    // the top bit says whether it reached 2 or more
    assign carry = prod.sig[`FLOAT_PROD_WIDTH-1];

    always_comb begin
        if (carry) begin
            // binary point sits one place further left
            mant_norm = prod.sig[`FLOAT_PROD_WIDTH-2 -: `FLOAT_MANT_WIDTH];
        end else begin
            mant_norm = prod.sig[`FLOAT_PROD_WIDTH-3 -: `FLOAT_MANT_WIDTH];
        end
    end

    // bump exponent on carry
    always_comb begin
        exp_adj = prod.exp + fmul_pkg::prod_exp_t'(carry);
    end

    // pack through the field view
    always_comb begin
        out_next.raw = '0;

        if (prod.valid && !prod.zero) begin
            out_next.fields.sign = prod.sign;
            // upper exponent bits dropped, no overflow handling
            out_next.fields.exp  = exp_adj[`FLOAT_EXP_WIDTH-1:0];
            out_next.fields.mant = mant_norm;
        end
    end

    // output register, ack follows the stage valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
            ack <= 1'b0;
        end else begin
            out <= out_next;
            ack <= prod.valid;
        end
    end

endmodule

/* rtl/float_mul_unit.sv */
// fixed 3-cycle latency, one request per cycle, no back-pressure so out must be taken on ack
`timescale 1ns/1ps

module float_mul_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  float_pkg::float_t  a,
    input  float_pkg::float_t  b,
    output logic               ack,
    output float_pkg::float_t  out
);

    // decoded operands, valid one cycle after req
    fmul_pkg::operand_pair_t  opnd;

    // raw product, valid two cycles after req
    fmul_pkg::product_t       prod;

    float_unpack u_float_unpack (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .a     (a),
        .b     (b),
        .opnd  (opnd)
    );

    float_mant_mul u_float_mant_mul (
        .clk   (clk),
        .rst   (rst),
        .opnd  (opnd),
        .prod  (prod)
    );

    // result and ack registered here, third cycle
    float_normalize u_float_normalize (
        .clk   (clk),
        .rst   (rst),
        .prod  (prod),
        .out   (out),
        .ack   (ack)
    );

endmodule

/* tb/float_mul_unit_assertions.sv */
// bound to float_mul_unit; ack timing check assumes the fixed 3-cycle latency
`timescale 1ns/1ps

module float_mul_unit_assertions (
    input logic               clk,
    input logic               rst,
    input logic               req,
    input logic               ack,
    input float_pkg::float_t  out
);

    // req travels through three stage registers before it shows as ack
    property ack_follows_req;
        @(posedge clk) disable iff (rst)
            ack == $past(req, 3);
    endproperty

    // no stale product on the bus between acks
    property out_zero_when_idle;
        @(posedge clk) disable iff (rst)
            !ack |-> (out.raw == '0);
    endproperty

    property ack_low_in_reset;
        @(posedge clk)
            rst |-> !ack;
    endproperty

    ack_follows_req_check: assert property (ack_follows_req)
        else $error("ack does not match req from three cycles earlier");

    out_zero_when_idle_check: assert property (out_zero_when_idle)
        else $error("out is not zero while ack is low");

    ack_low_in_reset_check: assert property (ack_low_in_reset)
        else $error("ack is high during reset");

endmodule

bind float_mul_unit float_mul_unit_assertions u_float_mul_unit_assertions (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .ack  (ack),
    .out  (out)
);

/* tb/float_mul_unit_tb.sv */
// self-checking testbench; needs assertions enabled, assumes the fixed 3-cycle latency
`timescale 1ns/1ps
`include "float_defines.svh"

module float_mul_unit_tb;

    localparam int CLK_HALF      = 2;
    localparam int DRAIN_TIMEOUT = 20;

    logic               clk;
    logic               rst;
    logic               req;
    float_pkg::float_t  a;
    float_pkg::float_t  b;
    logic               ack;
    float_pkg::float_t  out;

    // expected products in request order
    logic [`FLOAT_WIDTH-1:0]  expect_q[$];

    int           errors;
    int           checks;
    int           req_count;
    int           ack_count;
    int unsigned  seed_init;

    float_mul_unit u_float_mul_unit (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .a    (a),
        .b    (b),
        .ack  (ack),
        .out  (out)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // product rule from the word layout with truncation and no range checks
    function automatic logic [31:0] reference_product(input logic [31:0] x, input logic [31:0] y);
        logic [7:0]   ex;
        logic [7:0]   ey;
        logic [47:0]  p;
        logic [9:0]   e;
        logic [22:0]  m;
        logic         s;
        ex = x[30:23];
        ey = y[30:23];
        s  = x[31] ^ y[31];
        p  = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
        e  = {2'b00, ex} + {2'b00, ey} - 10'd127;
        if (p[47]) begin
            m = p[46:24];
            e = e + 10'd1;
        end else begin
            m = p[45:23];
        end
        if (ex == 8'd0 || ey == 8'd0) begin
            return 32'd0;
        end
        return {s, e[7:0], m};
    endfunction

    // exponent kept in 64..190 so the result exponent stays in 1..254
    function automatic logic [31:0] random_operand();
        logic [31:0]  r;
        logic [7:0]   e;
        r = $urandom;
        e = 8'(64 + ($urandom % 127));
        return {r[31], e, r[22:0]};
    endfunction

    task automatic send_request(input logic [31:0] x, input logic [31:0] y);
        @(negedge clk);
        req   = 1'b1;
        a.raw = x;
        b.raw = y;
        expect_q.push_back(reference_product(x, y));
        req_count++;
    endtask

    // operands keep changing while req is low
    task automatic idle_cycle();
        @(negedge clk);
        req   = 1'b0;
        a.raw = random_operand();
        b.raw = $urandom;
    endtask

    task automatic wait_for_drain(input string what);
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout in %s: %0d results were never acknowledged", what, expect_q.size());
            errors++;
            expect_q.delete();
        end
    endtask

    task automatic check_ack_balance(input int reqs_before, input int acks_before);
        checks++;
        if ((ack_count - acks_before) != (req_count - reqs_before)) begin
            $display("saw %0d acks for %0d requests", ack_count - acks_before,
                     req_count - reqs_before);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!rst && ack) begin
            ack_count++;
            if (expect_q.size() == 0) begin
                $display("unexpected ack at %0t with no request outstanding", $time);
                errors++;
            end else begin
                checks++;
                assert (out.raw == expect_q[0]) else begin
                    $display("FAIL %0t: out %h, expected %h", $time, out.raw, expect_q[0]);
                    errors++;
                end
                void'(expect_q.pop_front());
            end
        end
    end

    initial begin
        int errors_before;
        int reqs_before;
        int acks_before;
        seed_init = $urandom(32'h14e);
        rst       = 1'b1;
        req       = 1'b0;
        a.raw     = '0;
        b.raw     = '0;
        errors    = 0;
        checks    = 0;
        req_count = 0;
        ack_count = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // nonzero operands with req low must not reach out
        errors_before = errors;
        for (int i = 0; i < 10; i++) begin
            idle_cycle();
            checks++;
            assert (!ack && out.raw == '0) else begin
                $display("FAIL %0t: ack %b out %h with no request", $time, ack, out.raw);
                errors++;
            end
        end
        report_test("idle after reset", errors_before);

        // zero exponent with stray mantissa bits on either side
        errors_before = errors;
        reqs_before   = req_count;
        acks_before   = ack_count;
        send_request({1'b0, 8'd0, 23'h12345}, 32'h3fc00000);
        send_request(32'hc0a00000, {1'b1, 8'd0, 23'h7fffff});
        send_request({1'b1, 8'd0, 23'h0}, {1'b0, 8'd0, 23'h400001});
        idle_cycle();
        wait_for_drain("zero operands");
        check_ack_balance(reqs_before, acks_before);
        report_test("zero operands", errors_before);

        errors_before = errors;
        send_request(32'h3f800000, 32'h3fc00000);
        send_request(32'h3fc00000, 32'h3fc00000);
        send_request(32'h3f800000, 32'h3f800000);
        send_request({1'b0, 8'd167, 23'h200000}, {1'b0, 8'd77, 23'h600000});
        send_request({1'b0, 8'd200, 23'h0abcde}, {1'b0, 8'd100, 23'h7fffff});
        idle_cycle();
        wait_for_drain("carry and no carry");
        report_test("carry and no carry", errors_before);

        errors_before = errors;
        for (int s = 0; s < 4; s++) begin
            send_request({s[1], 31'h40490fdb}, {s[0], 31'h3fb504f3});
        end
        idle_cycle();
        wait_for_drain("mixed signs");
        report_test("mixed signs", errors_before);

        // back to back with several products in flight
        errors_before = errors;
        reqs_before   = req_count;
        acks_before   = ack_count;
        for (int i = 0; i < 200; i++) begin
            send_request(random_operand(), random_operand());
        end
        idle_cycle();
        wait_for_drain("back to back");
        check_ack_balance(reqs_before, acks_before);
        report_test("back to back", errors_before);

        errors_before = errors;
        reqs_before   = req_count;
        acks_before   = ack_count;
        for (int i = 0; i < 150; i++) begin
            if ($urandom % 2 == 0) begin
                send_request(random_operand(), random_operand());
            end else begin
                idle_cycle();
            end
        end
        idle_cycle();
        wait_for_drain("random gaps");
        check_ack_balance(reqs_before, acks_before);
        report_test("random gaps", errors_before);

        $display("checks %0d, requests %0d, acks %0d, errors %0d",
                 checks, req_count, ack_count, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* float_mul_unit.f */
+incdir+rtl
rtl/float_pkg.sv
rtl/fmul_pkg.sv
rtl/float_unpack.sv
rtl/float_mant_mul.sv
rtl/float_normalize.sv
rtl/float_mul_unit.sv
tb/float_mul_unit_assertions.sv
tb/float_mul_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the float_mul_unit testbench with Verilator.
# Exit status is non-zero unless the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -f float_mul_unit.f \
    --top-module float_mul_unit_tb -o float_mul_unit_sim > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/float_mul_unit_sim > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -qx "NO ERRORS" "$SIM_LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
